//--- design/icache_pkg.sv
package icache_pkg;

	localparam int NUM_WAYS = 2; // victim and lru logic assume two ways

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [NUM_WAYS-1:0] way_vec_t;
	typedef logic [7:0] beat_len_t;

	// line read request towards memory
	typedef struct packed {
		addr_t     addr; // line aligned byte address
		beat_len_t len;  // beats minus one
	} mem_read_req_t;

	// one beat back from memory
	typedef struct packed {
		logic  valid;
		logic  last;
		word_t data;
	} mem_read_resp_t;

	typedef enum logic [2:0] {
		ST_INVALIDATE,
		ST_LOOKUP,
		ST_REQUEST,
		ST_RECEIVE,
		ST_REPLAY
	} ctrl_state_t;

	// refill write from the controller, seen by tag and data arrays alike
	typedef struct packed {
		logic        we;        // data beat write
		way_vec_t    way;       // one-hot
		logic [15:0] set;       // upper bits unused
		logic [7:0]  offset;    // word in line
		word_t       data;
		logic [29:0] tag;       // wide enough for one word per line and one set
		logic        tag_valid;
		logic        tag_we;
	} refill_wr_t;

endpackage

//--- design/icache_tag_array.sv
`timescale 1ns/1ns

module icache_tag_array #(
	parameter int LINE_WORDS = 8,
	parameter int NUM_SETS   = 64
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic [$clog2(NUM_SETS)-1:0] i_rd_index,
	input  logic                        i_rd_en,
	input  icache_pkg::addr_t           i_cmp_addr,
	input  icache_pkg::refill_wr_t      i_wr,
	input  logic [$clog2(NUM_SETS)-1:0] i_clear_index,
	input  logic                        i_clear,
	output icache_pkg::way_vec_t        o_hit_vec,
	output logic                        o_hit_way
);

	localparam int OFF_W   = $clog2(LINE_WORDS);
	localparam int IDX_W   = $clog2(NUM_SETS);
	localparam int TAG_LSB = OFF_W + IDX_W + 2;
	localparam int TAG_W   = 32 - TAG_LSB;

	logic [TAG_W-1:0]    r_tag_mem [icache_pkg::NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] r_valid [icache_pkg::NUM_WAYS];
	logic [TAG_W-1:0]    r_rd_tag [icache_pkg::NUM_WAYS];
	logic                r_rd_valid [icache_pkg::NUM_WAYS];
	logic [TAG_W-1:0]    w_cmp_tag;
	logic [IDX_W-1:0]    w_wr_set;

	assign w_cmp_tag = i_cmp_addr[31:TAG_LSB];
	assign w_wr_set  = i_wr.set[IDX_W-1:0];

	for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
		always_ff @(posedge i_clk) begin
			if (i_wr.tag_we && i_wr.way[w]) begin
				r_tag_mem[w][w_wr_set] <= i_wr.tag[TAG_W-1:0];
			end
			if (i_rd_en) begin
				r_rd_tag[w] <= r_tag_mem[w][i_rd_index];
			end
		end

		// sweep wins over refill, they never overlap anyway
		always_ff @(posedge i_clk) begin
			if (i_clear) begin
				r_valid[w][i_clear_index] <= 1'b0;
			end else if (i_wr.tag_we && i_wr.way[w]) begin
				r_valid[w][w_wr_set] <= i_wr.tag_valid;
			end
		end

		always_ff @(posedge i_clk) begin
			if (i_rst) begin
				r_rd_valid[w] <= 1'b0;
			end else if (i_rd_en) begin
				r_rd_valid[w] <= r_valid[w][i_rd_index];
			end
		end

		assign o_hit_vec[w] = r_rd_valid[w] && (r_rd_tag[w] == w_cmp_tag);
	end

	assign o_hit_way = o_hit_vec[1]; // two ways only

endmodule

//--- design/icache_data_array.sv
`timescale 1ns/1ns

module icache_data_array #(
	parameter int LINE_WORDS = 8,
	parameter int NUM_SETS   = 64
) (
	input  logic                                          i_clk,
	input  logic [$clog2(NUM_SETS)-1:0]                   i_rd_index,
	input  logic [$clog2(LINE_WORDS)-1:0]                 i_rd_offset,
	input  logic                                          i_rd_en,
	input  icache_pkg::refill_wr_t                        i_wr,
	output icache_pkg::word_t [icache_pkg::NUM_WAYS-1:0]  o_rd_data
);

	localparam int OFF_W  = $clog2(LINE_WORDS);
	localparam int IDX_W  = $clog2(NUM_SETS);
	localparam int DEPTH  = NUM_SETS * LINE_WORDS;
	localparam int ADDR_W = IDX_W + OFF_W;

	icache_pkg::word_t r_mem [icache_pkg::NUM_WAYS][DEPTH];
	icache_pkg::word_t r_rd_data [icache_pkg::NUM_WAYS];
	logic [ADDR_W-1:0] w_rd_addr;
	logic [ADDR_W-1:0] w_wr_addr;

	assign w_rd_addr = {i_rd_index, i_rd_offset};
	assign w_wr_addr = {i_wr.set[IDX_W-1:0], i_wr.offset[OFF_W-1:0]};

	for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : g_way
		always_ff @(posedge i_clk) begin
			if (i_wr.we && i_wr.way[w]) begin
				r_mem[w][w_wr_addr] <= i_wr.data; // one beat per cycle
			end
			if (i_rd_en) begin
				r_rd_data[w] <= r_mem[w][w_rd_addr];
			end
		end

		assign o_rd_data[w] = r_rd_data[w];
	end

endmodule

//--- design/icache_refill_ctrl.sv
`timescale 1ns/1ns

module icache_refill_ctrl #(
	parameter int LINE_WORDS = 8,
	parameter int NUM_SETS   = 64
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_valid,
	input  icache_pkg::addr_t           i_addr,
	output logic                        o_ready,
	output icache_pkg::addr_t           o_lookup_addr,
	output logic                        o_stage2_valid,
	output icache_pkg::addr_t           o_stage2_addr,
	input  icache_pkg::way_vec_t        i_hit_vec,
	input  logic                        i_hit_way,
	output icache_pkg::refill_wr_t      o_wr,
	output logic                        o_clear,
	output logic [$clog2(NUM_SETS)-1:0] o_clear_index,
	output logic                        o_fwd_valid,
	output icache_pkg::word_t           o_fwd_data,
	output logic                        o_stall,
	output logic                        o_mem_req_valid,
	output icache_pkg::mem_read_req_t   o_mem_req,
	input  logic                        i_mem_req_ready,
	input  icache_pkg::mem_read_resp_t  i_mem_resp
);

	localparam int OFF_W    = $clog2(LINE_WORDS);
	localparam int IDX_W    = $clog2(NUM_SETS);
	localparam int LINE_LSB = OFF_W + 2;
	localparam int TAG_LSB  = LINE_LSB + IDX_W;

	icache_pkg::ctrl_state_t r_state;
	icache_pkg::ctrl_state_t w_next;
	logic                r_s1_valid;
	logic                r_s2_valid;
	icache_pkg::addr_t   r_s1_addr;
	icache_pkg::addr_t   r_s2_addr; // held through a miss, gives the line address
	logic [IDX_W-1:0]    r_sweep_cnt;
	logic [OFF_W-1:0]    r_beat_cnt;
	logic [NUM_SETS-1:0] r_lru; // way to evict next
	logic [IDX_W-1:0]    w_s2_index;
	logic [OFF_W-1:0]    w_s2_offset;
	logic                w_victim;
	logic                w_hit;
	logic                w_miss;
	logic                w_advance;
	logic                w_beat;
	logic                w_last_beat;

	assign w_s2_index  = r_s2_addr[LINE_LSB +: IDX_W];
	assign w_s2_offset = r_s2_addr[2 +: OFF_W];
	assign w_victim    = r_lru[w_s2_index];

	assign w_hit  = (r_state == icache_pkg::ST_LOOKUP) && r_s2_valid && (|i_hit_vec);
	assign w_miss = (r_state == icache_pkg::ST_LOOKUP) && r_s2_valid && !(|i_hit_vec);
	// replay moves the held younger request into stage 2
	assign w_advance = ((r_state == icache_pkg::ST_LOOKUP) && !w_miss)
		|| (r_state == icache_pkg::ST_REPLAY);
	assign w_beat      = (r_state == icache_pkg::ST_RECEIVE) && i_mem_resp.valid;
	assign w_last_beat = w_beat && i_mem_resp.last;

	assign o_ready        = w_advance;
	assign o_stall        = (r_state != icache_pkg::ST_LOOKUP);
	assign o_lookup_addr  = r_s1_addr; // held while stalled
	assign o_stage2_valid = r_s2_valid;
	assign o_stage2_addr  = r_s2_addr;

	always_comb begin
		w_next = r_state;
		case (r_state)
			icache_pkg::ST_INVALIDATE: begin
				if (r_sweep_cnt == IDX_W'(NUM_SETS - 1)) begin
					w_next = icache_pkg::ST_LOOKUP;
				end
			end
			icache_pkg::ST_LOOKUP: begin
				if (w_miss) begin
					w_next = i_mem_req_ready ? icache_pkg::ST_RECEIVE : icache_pkg::ST_REQUEST;
				end
			end
			icache_pkg::ST_REQUEST: begin
				if (i_mem_req_ready) begin
					w_next = icache_pkg::ST_RECEIVE;
				end
			end
			icache_pkg::ST_RECEIVE: begin
				if (w_last_beat) begin
					w_next = icache_pkg::ST_REPLAY;
				end
			end
			icache_pkg::ST_REPLAY: w_next = icache_pkg::ST_LOOKUP;
			default: w_next = icache_pkg::ST_INVALIDATE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state     <= icache_pkg::ST_INVALIDATE;
			r_sweep_cnt <= '0;
			r_s1_valid  <= 1'b0;
			r_s2_valid  <= 1'b0;
			r_beat_cnt  <= '0;
		end else begin
			r_state <= w_next;
			if (r_state == icache_pkg::ST_INVALIDATE) begin
				r_sweep_cnt <= r_sweep_cnt + 1'b1;
			end
			if (w_advance) begin
				r_s1_valid <= i_valid;
				r_s2_valid <= r_s1_valid;
			end
			if (o_mem_req_valid) begin
				r_beat_cnt <= '0;
			end else if (w_beat) begin
				r_beat_cnt <= r_beat_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_advance) begin
			r_s1_addr <= i_addr;
			r_s2_addr <= r_s1_addr;
		end
	end

	// lru bits cleared by the sweep along with the valid bits
	always_ff @(posedge i_clk) begin
		if (r_state == icache_pkg::ST_INVALIDATE) begin
			r_lru[r_sweep_cnt] <= 1'b0;
		end else if (w_hit) begin
			r_lru[w_s2_index] <= !i_hit_way;
		end else if (w_last_beat) begin
			r_lru[w_s2_index] <= !w_victim;
		end
	end

	assign o_mem_req_valid = w_miss || (r_state == icache_pkg::ST_REQUEST);
	assign o_mem_req.addr  = {r_s2_addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
	assign o_mem_req.len   = 8'(LINE_WORDS - 1);

	always_comb begin
		o_wr = '0;
		o_wr.we  = w_beat;
		o_wr.way = icache_pkg::way_vec_t'(1) << w_victim;
		o_wr.set[IDX_W-1:0]     = w_s2_index;
		o_wr.offset[OFF_W-1:0]  = r_beat_cnt;
		o_wr.data               = i_mem_resp.data;
		o_wr.tag[31-TAG_LSB:0]  = r_s2_addr[31:TAG_LSB];
		o_wr.tag_valid          = 1'b1;
		o_wr.tag_we             = w_last_beat; // line turns valid once complete
	end

	assign o_fwd_valid = w_beat && (r_beat_cnt == w_s2_offset); // critical word
	assign o_fwd_data  = i_mem_resp.data;

	assign o_clear       = (r_state == icache_pkg::ST_INVALIDATE);
	assign o_clear_index = r_sweep_cnt;

endmodule

//--- design/icache_hit_select.sv
`timescale 1ns/1ns

module icache_hit_select (
	input  logic                                         i_clk,
	input  logic                                         i_rst,
	input  logic                                         i_stage2_valid,
	input  logic                                         i_stall,
	input  icache_pkg::way_vec_t                         i_hit_vec,
	input  logic                                         i_hit_way,
	input  icache_pkg::word_t [icache_pkg::NUM_WAYS-1:0] i_way_data,
	input  logic                                         i_fwd_valid,
	input  icache_pkg::word_t                            i_fwd_data,
	output logic                                         o_valid,
	output icache_pkg::word_t                            o_data
);

	logic              w_hit;
	icache_pkg::word_t w_sel_data;
	logic              r_valid;
	icache_pkg::word_t r_data;

	// the missing request sits in stage 2 during a refill, no hit then
	assign w_hit = i_stage2_valid && !i_stall && (|i_hit_vec);

	// forwarded beat only shows up while stalled
	assign w_sel_data = i_fwd_valid ? i_fwd_data : i_way_data[i_hit_way];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_valid <= 1'b0;
		end else begin
			r_valid <= w_hit || i_fwd_valid; // one cycle per result
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_hit || i_fwd_valid) begin
			r_data <= w_sel_data;
		end
	end

	assign o_valid = r_valid;
	assign o_data  = r_data;

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ns

module icache_top #(
	parameter int LINE_WORDS = 8,
	parameter int NUM_SETS   = 64
) (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_valid,
	input  icache_pkg::addr_t          i_addr,
	output logic                       o_ready,
	output logic                       o_valid,
	output icache_pkg::word_t          o_data,
	output logic                       o_mem_req_valid,
	output icache_pkg::mem_read_req_t  o_mem_req,
	input  logic                       i_mem_req_ready,
	input  icache_pkg::mem_read_resp_t i_mem_resp
);

	localparam int OFF_W = $clog2(LINE_WORDS);
	localparam int IDX_W = $clog2(NUM_SETS);

	icache_pkg::addr_t      w_lookup_addr;
	icache_pkg::addr_t      w_stage2_addr;
	logic                   w_stage2_valid;
	icache_pkg::way_vec_t   w_hit_vec;
	logic                   w_hit_way;
	icache_pkg::refill_wr_t w_wr;
	logic                   w_clear;
	logic [IDX_W-1:0]       w_clear_index;
	logic                   w_fwd_valid;
	icache_pkg::word_t      w_fwd_data;
	logic                   w_stall;
	icache_pkg::word_t [icache_pkg::NUM_WAYS-1:0] w_way_data;

	icache_refill_ctrl #(
		.LINE_WORDS (LINE_WORDS),
		.NUM_SETS   (NUM_SETS)
	) u_refill_ctrl (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_valid         (i_valid),
		.i_addr          (i_addr),
		.o_ready         (o_ready),
		.o_lookup_addr   (w_lookup_addr),
		.o_stage2_valid  (w_stage2_valid),
		.o_stage2_addr   (w_stage2_addr),
		.i_hit_vec       (w_hit_vec),
		.i_hit_way       (w_hit_way),
		.o_wr            (w_wr),
		.o_clear         (w_clear),
		.o_clear_index   (w_clear_index),
		.o_fwd_valid     (w_fwd_valid),
		.o_fwd_data      (w_fwd_data),
		.o_stall         (w_stall),
		.o_mem_req_valid (o_mem_req_valid),
		.o_mem_req       (o_mem_req),
		.i_mem_req_ready (i_mem_req_ready),
		.i_mem_resp      (i_mem_resp)
	);

	// arrays read whenever the pipeline advances
	icache_tag_array #(
		.LINE_WORDS (LINE_WORDS),
		.NUM_SETS   (NUM_SETS)
	) u_tag_array (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_rd_index    (w_lookup_addr[OFF_W + 2 +: IDX_W]),
		.i_rd_en       (o_ready),
		.i_cmp_addr    (w_stage2_addr),
		.i_wr          (w_wr),
		.i_clear_index (w_clear_index),
		.i_clear       (w_clear),
		.o_hit_vec     (w_hit_vec),
		.o_hit_way     (w_hit_way)
	);

	icache_data_array #(
		.LINE_WORDS (LINE_WORDS),
		.NUM_SETS   (NUM_SETS)
	) u_data_array (
		.i_clk       (i_clk),
		.i_rd_index  (w_lookup_addr[OFF_W + 2 +: IDX_W]),
		.i_rd_offset (w_lookup_addr[2 +: OFF_W]),
		.i_rd_en     (o_ready),
		.i_wr        (w_wr),
		.o_rd_data   (w_way_data)
	);

	icache_hit_select u_hit_select (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_stage2_valid (w_stage2_valid),
		.i_stall        (w_stall),
		.i_hit_vec      (w_hit_vec),
		.i_hit_way      (w_hit_way),
		.i_way_data     (w_way_data),
		.i_fwd_valid    (w_fwd_valid),
		.i_fwd_data     (w_fwd_data),
		.o_valid        (o_valid),
		.o_data         (o_data)
	);

endmodule

//--- verification/icache_assertions.sv
`timescale 1ns/1ns

module icache_assertions #(
	parameter int LINE_WORDS = 8
) (
	input logic                      i_clk,
	input logic                      i_rst,
	input logic                      o_ready,
	input logic                      o_valid,
	input logic                      o_mem_req_valid,
	input icache_pkg::mem_read_req_t o_mem_req,
	input logic                      i_mem_req_ready
);

	localparam int LINE_LSB = $clog2(LINE_WORDS) + 2;

	a_quiet_after_reset: assert property (@(posedge i_clk)
		$fell(i_rst) |-> !o_valid && !o_mem_req_valid)
		else $error("valid output in the cycle after reset");

	a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		o_mem_req_valid && !i_mem_req_ready |=> o_mem_req_valid && $stable(o_mem_req))
		else $error("memory request changed before it was taken");

	a_req_shape: assert property (@(posedge i_clk) disable iff (i_rst)
		o_mem_req_valid |-> o_mem_req.addr[LINE_LSB-1:0] == '0
			&& o_mem_req.len == 8'(LINE_WORDS - 1))
		else $error("memory request not a whole aligned line");

	a_no_ready_on_req: assert property (@(posedge i_clk) disable iff (i_rst)
		o_mem_req_valid |-> !o_ready)
		else $error("o_ready high during a memory request");

endmodule

bind icache_top icache_assertions #(.LINE_WORDS(LINE_WORDS)) u_icache_assertions (
	.i_clk           (i_clk),
	.i_rst           (i_rst),
	.o_ready         (o_ready),
	.o_valid         (o_valid),
	.o_mem_req_valid (o_mem_req_valid),
	.o_mem_req       (o_mem_req),
	.i_mem_req_ready (i_mem_req_ready)
);

//--- verification/icache_tb.sv
`timescale 1ns/1ns

module icache_tb;

	localparam int LINE_WORDS   = 8;
	localparam int NUM_SETS     = 64;
	localparam int LINE_LSB     = $clog2(LINE_WORDS) + 2;
	localparam int IDX_W        = $clog2(NUM_SETS);
	localparam int NUM_ACCESSES = 85; // all tests together

	logic i_clk;
	logic i_rst;
	logic i_valid;
	logic o_ready;
	logic o_valid;
	logic o_mem_req_valid;
	logic i_mem_req_ready;
	icache_pkg::addr_t          i_addr;
	icache_pkg::word_t          o_data;
	icache_pkg::mem_read_req_t  o_mem_req;
	icache_pkg::mem_read_resp_t i_mem_resp;

	// reference model, line address per set and way
	logic [31:0] ref_line [NUM_SETS][2];
	logic        ref_vld [NUM_SETS][2];
	logic        ref_lru [NUM_SETS];
	icache_pkg::word_t         exp_words [$];
	icache_pkg::mem_read_req_t exp_reqs [$];
	icache_pkg::mem_read_req_t mem_req;
	int     errors     = 0;
	int     req_seen   = 0;
	int     req_pred   = 0;
	int     stall_span = 4;
	int     gap;
	integer seed = 43568;

	icache_top #(.LINE_WORDS(LINE_WORDS), .NUM_SETS(NUM_SETS)) u_icache_top (.*);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	task automatic check_word(input icache_pkg::word_t got, input icache_pkg::word_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: fetch returned %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_req(input icache_pkg::mem_read_req_t got,
		input icache_pkg::mem_read_req_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: memory request %h len %0d, expected %h len %0d",
				$time, got.addr, got.len, exp.addr, exp.len);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	// steps a plain two-way cache with true lru once per access
	task automatic predict(input icache_pkg::addr_t a);
		int idx, way;
		logic [31:0] line;
		icache_pkg::mem_read_req_t req;
		idx  = int'(a[LINE_LSB +: IDX_W]);
		line = a >> LINE_LSB;
		way  = -1;
		for (int w = 0; w < 2; w++) begin
			if (ref_vld[idx][w] && ref_line[idx][w] == line) way = w;
		end
		if (way < 0) begin
			way = int'(ref_lru[idx]);
			ref_line[idx][way] = line;
			ref_vld[idx][way]  = 1'b1;
			req.addr = line << LINE_LSB;
			req.len  = 8'(LINE_WORDS - 1);
			exp_reqs.push_back(req);
			req_pred++;
		end
		ref_lru[idx] = (way == 0); // other way goes next
		exp_words.push_back(a ^ 32'hA5A5_0000);
	endtask

	// holds the address until the cache takes it
	task automatic fetch(input icache_pkg::addr_t a);
		logic taken;
		predict(a);
		i_valid = 1'b1;
		i_addr  = a;
		do begin
			@(negedge i_clk);
			taken = o_ready;
			@(posedge i_clk);
			#1;
		end while (!taken);
		i_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_words.size() != 0 || exp_reqs.size() != 0) begin
			@(negedge i_clk);
		end
		check_count(req_seen, req_pred, "memory request count");
		@(posedge i_clk);
		#1;
	endtask

	// returned words in acceptance order
	always @(negedge i_clk) begin
		if (o_valid && exp_words.size() == 0) begin
			$display("Error at %0t ns: result returned with no fetch outstanding", $time);
			errors++;
		end else if (o_valid) begin
			check_word(o_data, exp_words.pop_front());
		end
	end

	// memory model returns each word as its address xor a fixed pattern
	always begin
		@(negedge i_clk);
		if (o_mem_req_valid) begin
			mem_req = o_mem_req;
			req_seen++;
			if (exp_reqs.size() == 0) begin
				$display("Error at %0t ns: memory request with no miss expected", $time);
				errors++;
			end else begin
				check_req(mem_req, exp_reqs.pop_front());
			end
			gap = int'({$random(seed)} % stall_span);
			@(posedge i_clk);
			#1;
			repeat (gap) begin
				@(posedge i_clk);
				#1;
			end
			i_mem_req_ready = 1'b1;
			check_req(o_mem_req, mem_req); // still the same request
			@(posedge i_clk);
			#1;
			i_mem_req_ready = 1'b0;
			for (int k = 0; k < LINE_WORDS; k++) begin
				if ($random(seed) % 2 != 0) begin
					@(posedge i_clk);
					#1;
				end
				i_mem_resp.valid = 1'b1;
				i_mem_resp.last  = (k == LINE_WORDS - 1);
				i_mem_resp.data  = (mem_req.addr + 32'(4 * k)) ^ 32'hA5A5_0000;
				@(posedge i_clk);
				#1;
				i_mem_resp = '0;
			end
		end
	end

	task automatic test_reset_sweep();
		int low = 0;
		foreach (ref_vld[s, w]) ref_vld[s][w] = 1'b0;
		foreach (ref_lru[s]) ref_lru[s] = 1'b0;
		i_rst = 1'b1;
		repeat (5) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		@(negedge i_clk);
		while (!o_ready) begin
			low++;
			@(negedge i_clk);
		end
		check_count(low, NUM_SETS, "cycles with o_ready low after reset");
		@(posedge i_clk);
		#1;
		fetch(32'h0000_0104);
		drain();
		check_count(req_seen, 1, "requests after the first fetch");
	endtask

	task automatic test_miss_words();
		fetch(32'h0000_021C); // last word of its line
		fetch(32'h0000_0308);
		drain();
	endtask

	task automatic test_hit_burst();
		int r0 = req_seen;
		for (int k = 0; k < LINE_WORDS; k++) begin
			fetch(32'h0000_0200 + 32'(4 * k));
		end
		// last hit comes out two edges after it was taken
		repeat (2) @(posedge i_clk);
		#1;
		check_count(int'(o_valid), 1, "o_valid two cycles after the last hit");
		check_word(o_data, 32'h0000_021C ^ 32'hA5A5_0000);
		drain();
		check_count(req_seen - r0, 0, "requests for a filled line");
	endtask

	// A B C all in set 5
	task automatic test_lru();
		icache_pkg::addr_t seq [6] = '{32'h10A0, 32'h20A0, 32'h10A4,
			32'h30A0, 32'h10A8, 32'h20A0};
		int r0 = req_seen;
		foreach (seq[k]) begin
			fetch(seq[k]);
		end
		drain();
		check_count(req_seen - r0, 4, "requests for A B A C A B");
	endtask

	task automatic test_back_pressure();
		stall_span = 16;
		for (int k = 0; k < 8; k++) begin
			fetch(32'h0000_4000 + 32'(k * 36)); // a new line and the next word each time
		end
		drain();
		stall_span = 4;
	endtask

	task automatic test_random_stream();
		for (int k = 0; k < 60; k++) begin
			fetch(32'h0001_0000 + ({$random(seed)} & 32'h0000_187C)); // 4 tags, 4 sets
		end
		drain();
	endtask

	initial begin
		i_rst           = 1'b1;
		i_valid         = 1'b0;
		i_addr          = '0;
		i_mem_req_ready = 1'b0;
		i_mem_resp      = '0;
		test_reset_sweep();
		test_miss_words();
		test_hit_burst();
		test_lru();
		test_back_pressure();
		test_random_stream();
		$display("Summary: %0d errors, %0d memory requests", errors, req_seen);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#(NUM_ACCESSES * 200);
		$display("Timeout: the cache stopped returning results in time");
		$display("Checks failed");
		$finish;
	end

endmodule

//--- icache_top.f
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_refill_ctrl.sv
design/icache_hit_select.sv
design/icache_top.sv
verification/icache_assertions.sv
verification/icache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	-f icache_top.f --top-module icache_tb -o icache_sim; then
	echo "build failed"
	exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "Checks failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation passed"
exit 0
